/* list.f */
+incdir+common
common/mmu_pkg.sv
tlb/tlb.sv
ptw/ptw.sv
logic/xlate_mux.sv
logic/mmu.sv
tests/tb_clock.sv
tests/mmu_tb.sv

/* tests/mmu_tb.sv */
`timescale 1ns/1ps
`include "mmu_settings.svh"

module mmu_tb;
    import mmu_pkg::*;

    localparam int N_PAGES = 24;
    localparam int N_BARE  = 8;
    localparam int N_XLATE = 60;
    localparam int N_FLUSH = 6;
    localparam int N_CONC  = 30;
    localparam int N_REQ   = 2 * N_BARE + 2 * N_XLATE + 3 * N_FLUSH + 2 * N_CONC;
    localparam ppn_t SATP  = 22'h000100;

    logic clk;
    logic reset_i;
    logic if_req_i;
    logic [`MMU_VALEN-1:0] if_vaddr_i;
    logic if_hit_o;
    logic [`MMU_PALEN-1:0] if_paddr_o;
    logic inst_page_fault_o;
    logic d_req_i;
    logic d_store_i;
    logic [`MMU_VALEN-1:0] d_vaddr_i;
    logic d_hit_o;
    logic [`MMU_PALEN-1:0] d_paddr_o;
    logic ld_page_fault_o;
    logic st_page_fault_o;
    logic [`MMU_VALEN-1:0] fault_vaddr_o;
    ppn_t satp_ppn_i;
    logic en_vaddr_i;
    logic en_ld_st_vaddr_i;
    logic mxr_i;
    logic tlb_flush_i;
    logic mem_req_valid_o;
    logic mem_req_ready_i;
    logic [`MMU_PALEN-1:0] mem_req_addr_o;
    logic mem_rsp_valid_i;
    logic [31:0] mem_rsp_data_i;

    // Sparse page-table memory, absent words read as invalid PTEs
    logic [31:0] pt_mem [logic [`MMU_PALEN-1:0]];
    logic [31:0] page_va [N_PAGES];
    logic [31:0] stim_seed;
    logic [31:0] mem_seed;
    int value_errs;
    int other_errs;
    int mem_count;

    tb_clock #(.PERIOD(20.0)) u_clock (.clk_o(clk));

    mmu u_mmu (.*);

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function logic [31:0] next_stim();
        stim_seed = lcg_step(stim_seed);
        return stim_seed ^ (stim_seed >> 16);
    endfunction

    function logic [31:0] next_mem();
        mem_seed = lcg_step(mem_seed);
        return mem_seed ^ (mem_seed >> 16);
    endfunction

    function automatic logic [31:0] pt_read(input logic [`MMU_PALEN-1:0] a);
        if (pt_mem.exists(a)) begin
            return pt_mem[a];
        end
        return 32'd0;
    endfunction

    function automatic logic perm_ok(input logic [31:0] pte, input access_e acc, input logic mxr);
        case (acc)
            ACC_FETCH: return pte[`MMU_PTE_X];
            ACC_LOAD:  return pte[`MMU_PTE_R] | (mxr & pte[`MMU_PTE_X]);
            default:   return pte[`MMU_PTE_W];
        endcase
    endfunction

    // Reference Sv32 walk over the model memory
    task automatic ref_walk(input logic [31:0] va, input access_e acc, input logic mxr,
                            output logic fault, output logic [`MMU_PALEN-1:0] pa);
        logic [31:0] pte;
        ppn_t ppn;
        fault = 1'b0;
        pa = '0;
        pte = pt_read({SATP, va[31:22], 2'b00});
        ppn = pte[31:10];
        if (!pte[0] || (pte[2] && !pte[1])) begin
            fault = 1'b1;
        end else if (pte[1] || pte[3]) begin
            fault = (ppn[9:0] != 10'd0) || !perm_ok(pte, acc, mxr);
            pa = {ppn[21:10], va[21:0]};
        end else begin
            pte = pt_read({ppn, va[21:12], 2'b00});
            ppn = pte[31:10];
            // Second level must be a valid leaf
            fault = !pte[0] || (pte[2] && !pte[1]) || !(pte[1] || pte[3])
                    || !perm_ok(pte, acc, mxr);
            pa = {ppn, va[11:0]};
        end
    endtask

    task automatic build_tables();
        logic [9:0] vpn1;
        logic [31:0] l1;
        logic [3:0] flags;
        ppn_t ppn;
        int kind;
        for (int i = 0; i < N_PAGES; i++) begin
            vpn1 = 10'(next_stim());
            if (!pt_mem.exists({SATP, vpn1, 2'b00})) begin
                kind = next_stim() % 8;
                ppn = 22'(next_stim());
                flags = {3'(next_stim()), 1'b1};
                if (flags[3:1] == 3'b000) begin
                    flags[1] = 1'b1;
                end
                if (kind == 0) begin
                    pt_mem[{SATP, vpn1, 2'b00}] = {ppn, 6'd0, 4'b0000};
                end else if (kind < 3) begin
                    // Mostly aligned superpages
                    if (next_stim() % 4 != 0) begin
                        ppn[9:0] = 10'd0;
                    end
                    pt_mem[{SATP, vpn1, 2'b00}] = {ppn, 6'd0, flags};
                end else begin
                    pt_mem[{SATP, vpn1, 2'b00}] = {22'h000200 + 22'(i), 6'd0, 4'b0001};
                end
            end
            l1 = pt_mem[{SATP, vpn1, 2'b00}];
            page_va[i] = {vpn1, 10'(next_stim()), 12'(next_stim())};
            if (l1[0] && !l1[1] && !l1[3]) begin
                flags = 4'(next_stim());
                flags[0] = (next_stim() % 8) != 0;
                pt_mem[{l1[31:10], page_va[i][21:12], 2'b00}] =
                    {22'(next_stim()), 6'd0, flags};
            end
        end
    endtask

    task automatic check_paddr(input string name, input logic [`MMU_PALEN-1:0] got,
                               input logic [`MMU_PALEN-1:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_hit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_fault(input access_e exp_acc, input logic [`MMU_VALEN-1:0] exp_va);
        logic [2:0] got;
        logic [2:0] exp;
        got = {inst_page_fault_o, ld_page_fault_o, st_page_fault_o};
        exp = {exp_acc == ACC_FETCH, exp_acc == ACC_LOAD, exp_acc == ACC_STORE};
        if (got !== exp) begin
            value_errs++;
            $display("ERR %0t page_fault_bits got %b expected %b", $time, got, exp);
        end
        if (fault_vaddr_o !== exp_va) begin
            value_errs++;
            $display("ERR %0t fault_vaddr_o got %h expected %h", $time, fault_vaddr_o, exp_va);
        end
    endtask

    // One request held until hit or fault, starting 2 ns after an edge
    task automatic do_access(input access_e acc, input logic [31:0] va, input bit first_hit);
        logic is_fetch;
        logic en;
        logic exp_fault;
        logic [`MMU_PALEN-1:0] exp_pa;
        logic got_hit;
        logic got_fault;
        int cycles;
        int mem_before;
        bit done;
        is_fetch = (acc == ACC_FETCH);
        en = is_fetch ? en_vaddr_i : en_ld_st_vaddr_i;
        exp_fault = 1'b0;
        exp_pa = {2'b00, va};
        if (en) begin
            ref_walk(va, acc, mxr_i, exp_fault, exp_pa);
        end
        mem_before = mem_count;
        cycles = 0;
        done = 0;
        if (is_fetch) begin
            if_vaddr_i = va;
            if_req_i = 1'b1;
        end else begin
            d_vaddr_i = va;
            d_store_i = (acc == ACC_STORE);
            d_req_i = 1'b1;
        end
        while (!done) begin
            @(negedge clk);
            got_hit = is_fetch ? if_hit_o : d_hit_o;
            got_fault = is_fetch ? inst_page_fault_o : (ld_page_fault_o | st_page_fault_o);
            if (got_hit || got_fault) begin
                done = 1;
                check_hit(is_fetch ? "if_hit_o" : "d_hit_o", got_hit, !exp_fault);
                if (got_fault) begin
                    check_fault(acc, va);
                end else begin
                    check_paddr(is_fetch ? "if_paddr_o" : "d_paddr_o",
                                is_fetch ? if_paddr_o : d_paddr_o, exp_pa);
                end
                if (first_hit && (cycles != 0 || mem_count != mem_before)) begin
                    other_errs++;
                    $display("Repeated access at %h did not hit at once without memory", va);
                end
            end else if (cycles > 200) begin
                done = 1;
                other_errs++;
                $display("Request for %h got neither hit nor fault in time", va);
            end
            cycles++;
        end
        @(posedge clk);
        #2;
        if (is_fetch) begin
            if_req_i = 1'b0;
        end else begin
            d_req_i = 1'b0;
        end
    endtask

    // Memory port with random ready stalls and response delays
    logic mem_acc;
    logic mem_waiting;
    logic rsp_pending;
    int rsp_delay;
    logic [`MMU_PALEN-1:0] rsp_addr;
    logic [`MMU_PALEN-1:0] prev_addr;

    always begin
        @(negedge clk);
        mem_acc = mem_req_valid_o && mem_req_ready_i;
        if (mem_waiting && mem_req_valid_o && mem_req_addr_o !== prev_addr) begin
            other_errs++;
            $display("Memory request address changed while waiting for ready");
        end
        if (mem_req_valid_o && !en_vaddr_i && !en_ld_st_vaddr_i) begin
            other_errs++;
            $display("Memory request raised while both sides are in bare mode");
        end
        mem_waiting = mem_req_valid_o && !mem_req_ready_i;
        prev_addr = mem_req_addr_o;
        @(posedge clk);
        #2;
        mem_rsp_valid_i = 1'b0;
        if (mem_acc) begin
            mem_count++;
            rsp_pending = 1'b1;
            rsp_delay = next_mem() % 6;
            rsp_addr = prev_addr;
        end
        if (rsp_pending) begin
            if (rsp_delay == 0) begin
                mem_rsp_valid_i = 1'b1;
                mem_rsp_data_i = pt_read(rsp_addr);
                rsp_pending = 1'b0;
            end else begin
                rsp_delay--;
            end
        end
        mem_req_ready_i = (next_mem() % 4) != 0;
    end

    // Watchdog sized from the request count
    initial begin
        #(N_REQ * 200 * 20);
        $display("Watchdog expired before all requests finished");
        $display("test failed");
        $finish;
    end

    initial begin
        access_e acc;
        access_e acc2;
        logic f;
        logic [`MMU_PALEN-1:0] pa;
        int idx;
        int mem_before;
        stim_seed = 32'h719a;
        mem_seed = 32'h719a ^ 32'h5555;
        value_errs = 0;
        other_errs = 0;
        mem_count = 0;
        mem_waiting = 1'b0;
        rsp_pending = 1'b0;
        rsp_delay = 0;
        reset_i = 1'b1;
        if_req_i = 1'b0;
        if_vaddr_i = '0;
        d_req_i = 1'b0;
        d_store_i = 1'b0;
        d_vaddr_i = '0;
        satp_ppn_i = SATP;
        en_vaddr_i = 1'b0;
        en_ld_st_vaddr_i = 1'b0;
        mxr_i = 1'b0;
        tlb_flush_i = 1'b0;
        mem_req_ready_i = 1'b0;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_data_i = '0;
        build_tables();
        repeat (4) @(posedge clk);
        #2;
        reset_i = 1'b0;

        // Bare mode on both sides
        for (int i = 0; i < N_BARE; i++) begin
            do_access(ACC_FETCH, next_stim(), 1'b1);
            do_access((next_stim() % 2) ? ACC_STORE : ACC_LOAD, next_stim(), 1'b1);
        end

        en_vaddr_i = 1'b1;
        en_ld_st_vaddr_i = 1'b1;

        // Walks, each followed by a repeat that should hit when it succeeded
        for (int i = 0; i < N_XLATE; i++) begin
            acc = access_e'(next_stim() % 3);
            idx = next_stim() % N_PAGES;
            mxr_i = (next_stim() % 3) == 0;
            ref_walk(page_va[idx], acc, mxr_i, f, pa);
            do_access(acc, page_va[idx], 1'b0);
            do_access(acc, page_va[idx] ^ (next_stim() & 32'hfff), !f);
        end

        // Flush forces a new walk
        for (int i = 0; i < N_FLUSH; i++) begin
            // Pick a page and access kind that translate, so a TLB entry exists
            f = 1'b1;
            for (int t = 0; t < 8 * N_PAGES && f; t++) begin
                acc = access_e'(next_stim() % 3);
                idx = next_stim() % N_PAGES;
                ref_walk(page_va[idx], acc, mxr_i, f, pa);
            end
            if (f) begin
                other_errs++;
                $display("No translating page found for the TLB flush test");
            end
            do_access(acc, page_va[idx], 1'b0);
            do_access(acc, page_va[idx], !f);
            tlb_flush_i = 1'b1;
            @(posedge clk);
            #2;
            tlb_flush_i = 1'b0;
            mem_before = mem_count;
            do_access(acc, page_va[idx], 1'b0);
            if (mem_count == mem_before) begin
                other_errs++;
                $display("No page-table read after a TLB flush");
            end
        end

        // Both sides at once under back-pressure
        for (int i = 0; i < N_CONC; i++) begin
            acc2 = (next_stim() % 2) ? ACC_STORE : ACC_LOAD;
            idx = next_stim() % N_PAGES;
            mxr_i = (next_stim() % 3) == 0;
            fork
                do_access(ACC_FETCH, page_va[next_stim() % N_PAGES], 1'b0);
                do_access(acc2, page_va[idx], 1'b0);
            join
        end

        repeat (4) @(posedge clk);
        $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD = 20.0
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always begin
        #(PERIOD / 2.0) clk_o = ~clk_o;
    end

endmodule

/* logic/mmu.sv */
`timescale 1ns/1ps
`include "mmu_settings.svh"

module mmu (
    input  logic                   clk,
    input  logic                   reset_i,

    // Fetch side
    input  logic                   if_req_i,
    input  logic [`MMU_VALEN-1:0]  if_vaddr_i,
    output logic                   if_hit_o,
    output logic [`MMU_PALEN-1:0]  if_paddr_o,
    output logic                   inst_page_fault_o,

    // Load/store side
    input  logic                   d_req_i,
    input  logic                   d_store_i,
    input  logic [`MMU_VALEN-1:0]  d_vaddr_i,
    output logic                   d_hit_o,
    output logic [`MMU_PALEN-1:0]  d_paddr_o,
    output logic                   ld_page_fault_o,
    output logic                   st_page_fault_o,
    output logic [`MMU_VALEN-1:0]  fault_vaddr_o,

    // CSR state
    input  mmu_pkg::ppn_t          satp_ppn_i,
    input  logic                   en_vaddr_i,
    input  logic                   en_ld_st_vaddr_i,
    input  logic                   mxr_i,
    input  logic                   tlb_flush_i,

    // Page-table memory port
    output logic                   mem_req_valid_o,
    input  logic                   mem_req_ready_i,
    output logic [`MMU_PALEN-1:0]  mem_req_addr_o,
    input  logic                   mem_rsp_valid_i,
    input  logic [31:0]            mem_rsp_data_i
);
    import mmu_pkg::*;

    access_e d_acc;

    logic    itlb_hit;
    ppn_t    itlb_ppn;
    logic    itlb_super;
    logic    dtlb_hit;
    ppn_t    dtlb_ppn;
    logic    dtlb_super;

    logic    i_miss;
    logic    d_miss;

    // Shared fill bus
    vpn_t    fill_vpn;
    ppn_t    fill_ppn;
    logic    fill_super;
    logic    fill_r;
    logic    fill_w;
    logic    fill_x;
    logic    itlb_fill;
    logic    dtlb_fill;

    assign d_acc = d_store_i ? ACC_STORE : ACC_LOAD;

    tlb #(
        .ENTRIES (`MMU_ITLB_ENTRIES)
    ) u_itlb (
        .clk            (clk),
        .reset_i        (reset_i),
        .lookup_valid_i (if_req_i),
        .lookup_vpn_i   (if_vaddr_i[`MMU_VALEN-1:`MMU_PAGE_BITS]),
        .lookup_acc_i   (ACC_FETCH),
        .mxr_i          (mxr_i),
        .flush_i        (tlb_flush_i),
        .fill_i         (itlb_fill),
        .fill_vpn_i     (fill_vpn),
        .fill_ppn_i     (fill_ppn),
        .fill_super_i   (fill_super),
        .fill_r_i       (fill_r),
        .fill_w_i       (fill_w),
        .fill_x_i       (fill_x),
        .lookup_hit_o   (itlb_hit),
        .lookup_ppn_o   (itlb_ppn),
        .lookup_super_o (itlb_super)
    );

    tlb #(
        .ENTRIES (`MMU_DTLB_ENTRIES)
    ) u_dtlb (
        .clk            (clk),
        .reset_i        (reset_i),
        .lookup_valid_i (d_req_i),
        .lookup_vpn_i   (d_vaddr_i[`MMU_VALEN-1:`MMU_PAGE_BITS]),
        .lookup_acc_i   (d_acc),
        .mxr_i          (mxr_i),
        .flush_i        (tlb_flush_i),
        .fill_i         (dtlb_fill),
        .fill_vpn_i     (fill_vpn),
        .fill_ppn_i     (fill_ppn),
        .fill_super_i   (fill_super),
        .fill_r_i       (fill_r),
        .fill_w_i       (fill_w),
        .fill_x_i       (fill_x),
        .lookup_hit_o   (dtlb_hit),
        .lookup_ppn_o   (dtlb_ppn),
        .lookup_super_o (dtlb_super)
    );

    xlate_mux u_ixlate (
        .en_i        (en_vaddr_i),
        .req_i       (if_req_i),
        .vaddr_i     (if_vaddr_i),
        .tlb_hit_i   (itlb_hit),
        .tlb_ppn_i   (itlb_ppn),
        .tlb_super_i (itlb_super),
        .hit_o       (if_hit_o),
        .paddr_o     (if_paddr_o),
        .miss_o      (i_miss)
    );

    xlate_mux u_dxlate (
        .en_i        (en_ld_st_vaddr_i),
        .req_i       (d_req_i),
        .vaddr_i     (d_vaddr_i),
        .tlb_hit_i   (dtlb_hit),
        .tlb_ppn_i   (dtlb_ppn),
        .tlb_super_i (dtlb_super),
        .hit_o       (d_hit_o),
        .paddr_o     (d_paddr_o),
        .miss_o      (d_miss)
    );

    ptw u_ptw (
        .clk               (clk),
        .reset_i           (reset_i),
        .satp_ppn_i        (satp_ppn_i),
        .mxr_i             (mxr_i),
        .i_miss_i          (i_miss),
        .i_vaddr_i         (if_vaddr_i),
        .d_miss_i          (d_miss),
        .d_store_i         (d_store_i),
        .d_vaddr_i         (d_vaddr_i),
        .mem_req_valid_o   (mem_req_valid_o),
        .mem_req_ready_i   (mem_req_ready_i),
        .mem_req_addr_o    (mem_req_addr_o),
        .mem_rsp_valid_i   (mem_rsp_valid_i),
        .mem_rsp_data_i    (mem_rsp_data_i),
        .fill_vpn_o        (fill_vpn),
        .fill_ppn_o        (fill_ppn),
        .fill_super_o      (fill_super),
        .fill_r_o          (fill_r),
        .fill_w_o          (fill_w),
        .fill_x_o          (fill_x),
        .itlb_fill_o       (itlb_fill),
        .dtlb_fill_o       (dtlb_fill),
        .inst_page_fault_o (inst_page_fault_o),
        .ld_page_fault_o   (ld_page_fault_o),
        .st_page_fault_o   (st_page_fault_o),
        .fault_vaddr_o     (fault_vaddr_o)
    );

endmodule

/* logic/xlate_mux.sv */
`timescale 1ns/1ps
`include "mmu_settings.svh"

module xlate_mux (
    input  logic                   en_i,
    input  logic                   req_i,
    input  logic [`MMU_VALEN-1:0]  vaddr_i,

    input  logic                   tlb_hit_i,
    input  mmu_pkg::ppn_t          tlb_ppn_i,
    input  logic                   tlb_super_i,

    output logic                   hit_o,
    output logic [`MMU_PALEN-1:0]  paddr_o,
    output logic                   miss_o
);
    import mmu_pkg::*;

    always_comb begin
        // Bare mode passes the address straight through
        paddr_o = {2'b00, vaddr_i};
        hit_o   = req_i;

        if (en_i) begin
            paddr_o = {tlb_ppn_i, vaddr_i[`MMU_PAGE_BITS-1:0]};
            hit_o   = req_i & tlb_hit_i;

            // 4 MiB page keeps VPN[0] as part of the offset
            if (tlb_super_i) begin
                paddr_o[21:12] = vaddr_i[21:12];
            end
        end
    end

    // Walk request for this side
    assign miss_o = req_i & en_i & ~tlb_hit_i;

endmodule

/* ptw/ptw.sv */
`timescale 1ns/1ps
`include "mmu_settings.svh"

module ptw (
    input  logic                   clk,
    input  logic                   reset_i,

    input  mmu_pkg::ppn_t          satp_ppn_i,
    input  logic                   mxr_i,

    input  logic                   i_miss_i,
    input  logic [`MMU_VALEN-1:0]  i_vaddr_i,
    input  logic                   d_miss_i,
    input  logic                   d_store_i,
    input  logic [`MMU_VALEN-1:0]  d_vaddr_i,

    output logic                   mem_req_valid_o,
    input  logic                   mem_req_ready_i,
    output logic [`MMU_PALEN-1:0]  mem_req_addr_o,
    input  logic                   mem_rsp_valid_i,
    input  logic [31:0]            mem_rsp_data_i,

    output mmu_pkg::vpn_t          fill_vpn_o,
    output mmu_pkg::ppn_t          fill_ppn_o,
    output logic                   fill_super_o,
    output logic                   fill_r_o,
    output logic                   fill_w_o,
    output logic                   fill_x_o,
    output logic                   itlb_fill_o,
    output logic                   dtlb_fill_o,

    output logic                   inst_page_fault_o,
    output logic                   ld_page_fault_o,
    output logic                   st_page_fault_o,
    output logic [`MMU_VALEN-1:0]  fault_vaddr_o
);
    import mmu_pkg::*;

    ptw_state_e            state_q;
    ptw_state_e            state_d;

    // Walk context, latched when a walk starts
    logic [`MMU_VALEN-1:0] vaddr_q;
    access_e               acc_q;
    ppn_t                  base_ppn_q;

    // Leaf captured for the fill
    ppn_t                  leaf_ppn_q;
    logic                  leaf_super_q;
    logic                  leaf_r_q;
    logic                  leaf_w_q;
    logic                  leaf_x_q;

    logic                  pte_v;
    logic                  pte_r;
    logic                  pte_w;
    logic                  pte_x;
    ppn_t                  pte_ppn;
    logic                  pte_leaf;
    logic                  pte_bad;
    logic                  pte_perm_ok;
    logic                  pte_misaligned;
    logic [9:0]            vpn_sel;

    // Decode of the returned PTE
    assign pte_v          = mem_rsp_data_i[`MMU_PTE_V];
    assign pte_r          = mem_rsp_data_i[`MMU_PTE_R];
    assign pte_w          = mem_rsp_data_i[`MMU_PTE_W];
    assign pte_x          = mem_rsp_data_i[`MMU_PTE_X];
    assign pte_ppn        = mem_rsp_data_i[31:`MMU_PTE_PPN_LSB];
    assign pte_leaf       = pte_r | pte_x;
    assign pte_bad        = !pte_v || (pte_w && !pte_r);
    assign pte_misaligned = (pte_ppn[9:0] != 10'd0);

    always_comb begin
        case (acc_q)
            ACC_FETCH: pte_perm_ok = pte_x;
            ACC_LOAD:  pte_perm_ok = pte_r | (mxr_i & pte_x);
            ACC_STORE: pte_perm_ok = pte_w;
            default:   pte_perm_ok = 1'b0;
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            PTW_IDLE: begin
                if (d_miss_i || i_miss_i) begin
                    state_d = PTW_L1_REQ;
                end
            end
            PTW_L1_REQ: begin
                if (mem_req_ready_i) begin
                    state_d = PTW_L1_WAIT;
                end
            end
            PTW_L1_WAIT: begin
                if (mem_rsp_valid_i) begin
                    if (pte_bad) begin
                        state_d = PTW_FAULT;
                    end else if (!pte_leaf) begin
                        state_d = PTW_L0_REQ;
                    end else if (pte_misaligned || !pte_perm_ok) begin
                        state_d = PTW_FAULT;
                    end else begin
                        state_d = PTW_FILL;
                    end
                end
            end
            PTW_L0_REQ: begin
                if (mem_req_ready_i) begin
                    state_d = PTW_L0_WAIT;
                end
            end
            PTW_L0_WAIT: begin
                // A pointer at this level is a fault as well
                if (mem_rsp_valid_i) begin
                    if (pte_bad || !pte_leaf || !pte_perm_ok) begin
                        state_d = PTW_FAULT;
                    end else begin
                        state_d = PTW_FILL;
                    end
                end
            end
            default: state_d = PTW_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= PTW_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        // Data side has priority over fetch
        if (state_q == PTW_IDLE) begin
            base_ppn_q <= satp_ppn_i;
            if (d_miss_i) begin
                vaddr_q <= d_vaddr_i;
                acc_q   <= d_store_i ? ACC_STORE : ACC_LOAD;
            end else if (i_miss_i) begin
                vaddr_q <= i_vaddr_i;
                acc_q   <= ACC_FETCH;
            end
        end

        if (mem_rsp_valid_i && (state_q == PTW_L1_WAIT || state_q == PTW_L0_WAIT)) begin
            base_ppn_q   <= pte_ppn;
            leaf_ppn_q   <= pte_ppn;
            leaf_super_q <= (state_q == PTW_L1_WAIT);
            leaf_r_q     <= pte_r;
            leaf_w_q     <= pte_w;
            leaf_x_q     <= pte_x;
        end
    end

    // PTE address is base PPN, VPN slice and 4-byte index
    assign vpn_sel         = (state_q == PTW_L0_REQ) ? vaddr_q[21:12] : vaddr_q[31:22];
    assign mem_req_addr_o  = {base_ppn_q, vpn_sel, 2'b00};
    assign mem_req_valid_o = (state_q == PTW_L1_REQ) || (state_q == PTW_L0_REQ);

    assign fill_vpn_o   = vaddr_q[`MMU_VALEN-1:`MMU_PAGE_BITS];
    assign fill_ppn_o   = leaf_ppn_q;
    assign fill_super_o = leaf_super_q;
    assign fill_r_o     = leaf_r_q;
    assign fill_w_o     = leaf_w_q;
    assign fill_x_o     = leaf_x_q;
    assign itlb_fill_o  = (state_q == PTW_FILL) && (acc_q == ACC_FETCH);
    assign dtlb_fill_o  = (state_q == PTW_FILL) && (acc_q != ACC_FETCH);

    assign inst_page_fault_o = (state_q == PTW_FAULT) && (acc_q == ACC_FETCH);
    assign ld_page_fault_o   = (state_q == PTW_FAULT) && (acc_q == ACC_LOAD);
    assign st_page_fault_o   = (state_q == PTW_FAULT) && (acc_q == ACC_STORE);
    assign fault_vaddr_o     = vaddr_q;

endmodule

/* tlb/tlb.sv */
`timescale 1ns/1ps
`include "mmu_settings.svh"

module tlb #(
    parameter int ENTRIES = `MMU_ITLB_ENTRIES
) (
    input  logic               clk,
    input  logic               reset_i,

    input  logic               lookup_valid_i,
    input  mmu_pkg::vpn_t      lookup_vpn_i,
    input  mmu_pkg::access_e   lookup_acc_i,
    input  logic               mxr_i,
    input  logic               flush_i,

    input  logic               fill_i,
    input  mmu_pkg::vpn_t      fill_vpn_i,
    input  mmu_pkg::ppn_t      fill_ppn_i,
    input  logic               fill_super_i,
    input  logic               fill_r_i,
    input  logic               fill_w_i,
    input  logic               fill_x_i,

    output logic               lookup_hit_o,
    output mmu_pkg::ppn_t      lookup_ppn_o,
    output logic               lookup_super_o
);
    import mmu_pkg::*;

    localparam int IDX_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

    logic [ENTRIES-1:0] valid_q;
    vpn_t               vpn_q   [ENTRIES];
    ppn_t               ppn_q   [ENTRIES];
    logic [ENTRIES-1:0] super_q;
    logic [ENTRIES-1:0] r_q;
    logic [ENTRIES-1:0] w_q;
    logic [ENTRIES-1:0] x_q;

    logic [IDX_W-1:0]   victim_q;
    logic [ENTRIES-1:0] tag_match;
    logic [ENTRIES-1:0] perm_ok;

    // Tag compare and permission check per entry
    always_comb begin
        for (int i = 0; i < ENTRIES; i++) begin
            // Superpages only look at VPN[1]
            if (super_q[i]) begin
                tag_match[i] = valid_q[i] && (vpn_q[i][19:10] == lookup_vpn_i[19:10]);
            end else begin
                tag_match[i] = valid_q[i] && (vpn_q[i] == lookup_vpn_i);
            end

            case (lookup_acc_i)
                ACC_FETCH: perm_ok[i] = x_q[i];
                ACC_LOAD:  perm_ok[i] = r_q[i] | (mxr_i & x_q[i]);
                ACC_STORE: perm_ok[i] = w_q[i];
                default:   perm_ok[i] = 1'b0;
            endcase
        end
    end

    // Lowest matching entry wins
    always_comb begin
        lookup_hit_o   = 1'b0;
        lookup_ppn_o   = '0;
        lookup_super_o = 1'b0;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (lookup_valid_i && tag_match[i] && perm_ok[i]) begin
                lookup_hit_o   = 1'b1;
                lookup_ppn_o   = ppn_q[i];
                lookup_super_o = super_q[i];
            end
        end
    end

    // Valid bits and round-robin pointer
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q  <= '0;
            victim_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (fill_i) begin
            valid_q[victim_q] <= 1'b1;
            if (victim_q == IDX_W'(ENTRIES - 1)) begin
                victim_q <= '0;
            end else begin
                victim_q <= victim_q + 1'b1;
            end
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (fill_i) begin
            vpn_q[victim_q]   <= fill_vpn_i;
            ppn_q[victim_q]   <= fill_ppn_i;
            super_q[victim_q] <= fill_super_i;
            r_q[victim_q]     <= fill_r_i;
            w_q[victim_q]     <= fill_w_i;
            x_q[victim_q]     <= fill_x_i;
        end
    end

endmodule

/* common/mmu_pkg.sv */
package mmu_pkg;

    // Kind of access behind a translation request
    typedef enum logic [1:0] {
        ACC_FETCH = 2'd0,
        ACC_LOAD  = 2'd1,
        ACC_STORE = 2'd2
    } access_e;

    // Page-table walker states
    typedef enum logic [2:0] {
        PTW_IDLE    = 3'd0,
        PTW_L1_REQ  = 3'd1,
        PTW_L1_WAIT = 3'd2,
        PTW_L0_REQ  = 3'd3,
        PTW_L0_WAIT = 3'd4,
        PTW_FILL    = 3'd5,
        PTW_FAULT   = 3'd6
    } ptw_state_e;

    // Virtual page number, VPN[1] in the upper 10 bits
    typedef logic [19:0] vpn_t;

    // Physical page number of a 34-bit physical address
    typedef logic [21:0] ppn_t;

endpackage

/* common/mmu_settings.svh */
`ifndef MMU_SETTINGS_SVH
`define MMU_SETTINGS_SVH

// Address widths for Sv32
`define MMU_VALEN 32
`define MMU_PALEN 34

// 4 KiB page offset
`define MMU_PAGE_BITS 12

// PTE flag positions
`define MMU_PTE_V 0
`define MMU_PTE_R 1
`define MMU_PTE_W 2
`define MMU_PTE_X 3

// PPN field starts above the flags and RSW bits
`define MMU_PTE_PPN_LSB 10

// TLB depths
`define MMU_ITLB_ENTRIES 8
`define MMU_DTLB_ENTRIES 8

`endif
